// File: Bender.yml
package:
  name: test_engine_node

sources:
  - files:
      - hdl/nic_flit_pkg.sv
      - hdl/engine_pkg.sv
      - hdl/nic_input_control.sv
      - hdl/nic_input_block.sv
      - hdl/test_engine_core.sv
      - hdl/nic_output_block.sv
      - hdl/test_engine_node.sv
  - target: simulation
    files:
      - dv/test_engine_node_tb.sv

// File: dv/test_engine_node_tb.sv
`timescale 1ns/1ps
`default_nettype none

// random five flit packets through the node, every output flit is compared with a
// model of the mixing rounds kept in the testbench
module test_engine_node_tb
	import nic_flit_pkg::*, engine_pkg::*;
;

	localparam int engine_rounds = 8;
	localparam int credit_count = 2;
	localparam int num_packets = 200;
	localparam int packet_cycles = 5 + 6 + engine_rounds + 20;  // worst case per packet
	localparam int timeout_cycles = num_packets * packet_cycles * 2;

	logic  clk;
	logic  rst_n;
	logic  credit_in;
	logic  rx_ready;
	flit_t rx_channel;
	flit_t tx_channel;

	flit_t exp_q[$];          // expected output flits, header first, in arrival order
	int    credit_due[$];     // cycle in which each pending credit goes back
	logic  hdr_pulse;         // one cycle after the monitor saw an output header
	int    received = 0;      // complete output packets
	int    outstanding = 0;   // output packets whose credit is not back yet
	int    mismatch_count = 0;
	int    other_errors = 0;

	test_engine_node #(.engine_rounds(engine_rounds), .credit_count(credit_count)) DUT
	(
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_channel (rx_channel),
		.credit_in  (credit_in),
		.rx_ready   (rx_ready),
		.tx_channel (tx_channel)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// ##########################################################################
	// model and helpers
	// ##########################################################################

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected)
		begin
			mismatch_count++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// x takes the sum, then y is rotated left and folded with the new x
	function automatic void mix_rounds(input word_t a, input word_t b,
			output word_t x, output word_t y);
		x = a;
		y = b;
		for (int r = 0; r < engine_rounds; r++)
		begin
			x = x + y;  // wraps modulo 2^64
			y = {y[63-mix_rotate:0], y[63:64-mix_rotate]} ^ x;
		end
	endfunction

	// called on the edge where rx_ready was seen high, header goes out right away
	task automatic send_packet();
		flit_t header;
		flit_t expected_header;
		word_t a, b, x, y;
		flit_t flits [data_flits];
		header = {1'b1, 1'($urandom), header_field_t'($urandom)};  // flag bit is random too
		a = {$urandom, $urandom};
		b = {$urandom, $urandom};
		mix_rounds(a, b, x, y);
		expected_header = header;
		expected_header[proc_flag_bit] = 1'b1;  // the node marks its result packets
		exp_q.push_back(expected_header);
		exp_q.push_back(x[63:32]);
		exp_q.push_back(x[31:0]);
		exp_q.push_back(y[63:32]);
		exp_q.push_back(y[31:0]);
		flits = '{a[63:32], a[31:0], b[63:32], b[31:0]};
		rx_channel <= header;
		for (int i = 0; i < data_flits; i++)
		begin
			@(posedge clk);
			if (i > 0)
				check_value("rx_ready", rx_ready, 1'b0);  // capture is under way
			rx_channel <= flits[i];
		end
		@(posedge clk);
		check_value("rx_ready", rx_ready, 1'b0);
		rx_channel <= flit_t'($urandom) & ~(flit_t'(1) << header_bit);  // idle noise
	endtask

	// ##########################################################################
	// stimulus
	// ##########################################################################

	initial
	begin : stimulus
		void'($urandom(32'h9a61));
		rst_n = 1'b0;
		rx_channel = '0;
		repeat (10) @(posedge clk);
		check_value("tx_channel", tx_channel, '0);  // values left by the reset cycles
		check_value("rx_ready", rx_ready, 1'b1);
		rst_n <= 1'b1;
		for (int p = 0; p < num_packets; p++)
		begin
			repeat ($urandom_range(4)) @(posedge clk);  // idle gap
			@(posedge clk);
			while (!rx_ready)
				@(posedge clk);
			send_packet();
		end
		while (received < num_packets)
			@(posedge clk);
		repeat (100) @(posedge clk);  // room for any packet that should not be there
		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d expected flits never came out of the node", exp_q.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// collects the header flit and the four flits behind it
	initial
	begin : monitor
		int flit_idx;  // 0 while waiting for a header
		flit_t expected;
		string flit_name;
		flit_idx = 0;
		hdr_pulse = 1'b0;
		forever
		begin
			@(posedge clk);
			hdr_pulse <= 1'b0;
			if (rst_n && (flit_idx > 0 || tx_channel[header_bit]))
			begin
				if (exp_q.size() == 0)
				begin
					other_errors++;
					$display("output flit %h at %0t with no packet expected", tx_channel, $time);
				end
				else
				begin
					expected = exp_q.pop_front();
					if (flit_idx == 0)
						flit_name = "tx_channel header";
					else
						flit_name = "tx_channel data";
					check_value(flit_name, tx_channel, expected);
				end
				if (flit_idx == 0)
				begin
					hdr_pulse <= 1'b1;
					outstanding++;
					if (outstanding > credit_count)
					begin
						other_errors++;
						$display("more packets out than credits allow at %0t", $time);
					end
				end
				flit_idx = (flit_idx == data_flits) ? 0 : flit_idx + 1;
				if (flit_idx == 0)
					received++;
			end
			if (credit_in)
				outstanding--;  // the credit counter in the node takes it with this edge
		end
	end

	// downstream returns a credit some cycles after each header, slowly in the second half
	initial
	begin : credit_return
		int now;
		int hdr_count;
		int idx;
		credit_in = 1'b0;
		now = 0;
		hdr_count = 0;
		forever
		begin
			@(posedge clk);
			now++;
			credit_in <= 1'b0;
			if (hdr_pulse)
			begin
				if (hdr_count >= num_packets / 2)
					credit_due.push_back(now + $urandom_range(60, 40));
				else
					credit_due.push_back(now + $urandom_range(20));
				hdr_count++;
			end
			idx = -1;
			foreach (credit_due[i])
			begin
				if (idx < 0 && credit_due[i] <= now)
					idx = i;
			end
			if (idx >= 0)
			begin
				credit_due.delete(idx);  // at most one credit per cycle
				credit_in <= 1'b1;
			end
		end
	end

	initial
	begin : watchdog
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout with %0d of %0d packets out of the node", received, num_packets);
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

endmodule : test_engine_node_tb

`default_nettype wire

// File: hdl/engine_pkg.sv
`default_nettype none

// ##########################################################################
// operand format and round constants of the mixing engine
// ##########################################################################

package engine_pkg;

	localparam int word_width = 64;   // two channel flits make one word

	// operand and result word, arithmetic on it wraps modulo 2^64
	typedef logic [word_width-1:0] word_t;

	// rotation of the y half in every round
	localparam int mix_rotate = 13;

endpackage : engine_pkg

`default_nettype wire

// File: hdl/nic_flit_pkg.sv
`default_nettype none

// ##########################################################################
// flit format of the router port channels
// ##########################################################################

package nic_flit_pkg;

	// channel geometry
	localparam int channel_width = 32;         // one flit per cycle on either channel
	localparam int data_flits = 4;             // data flits behind every header flit

	// header flit layout
	localparam int header_bit = 31;            // marks the first flit of a packet
	localparam int proc_flag_bit = 30;         // set by the node on its result packet
	localparam int header_field_width = 30;    // bits 29:0 travel through the node untouched

	// one flit as it sits on the channel
	typedef logic [channel_width-1:0] flit_t;

	// header payload without the marker and the processing flag, both of which the
	// output side rebuilds on its own
	typedef logic [header_field_width-1:0] header_field_t;

endpackage : nic_flit_pkg

`default_nettype wire

// File: hdl/nic_input_block.sv
`timescale 1ns/1ps
`default_nettype none

// input side of the node
// captures one five flit packet into a header register and a data bank and presents
// the data flits paired up as the two engine operands
module nic_input_block
	import nic_flit_pkg::*, engine_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  flit_t         rx_channel,
	input  logic          engine_busy,
	input  logic          zero_credits,
	output word_t         word_a,
	output word_t         word_b,
	output header_field_t header_field,
	output logic          transfer_strobe,
	output logic          rx_ready
);

	logic                write_strobe;
	logic [data_flits:0] register_enable;

	header_field_t header_reg;               // marker and flag bits are dropped here
	flit_t         data_bank [data_flits];   // data flits in arrival order

	nic_input_control u_input_control
	(
		.clk             (clk),
		.rst_n           (rst_n),
		.header_marker   (rx_channel[header_bit]),
		.engine_busy     (engine_busy),
		.zero_credits    (zero_credits),
		.transfer_strobe (transfer_strobe),
		.write_strobe    (write_strobe),
		.register_enable (register_enable),
		.rx_ready        (rx_ready)
	);

	// ##########################################################################
	// capture registers
	// ##########################################################################

	always_ff @(posedge clk)
	begin
		if (write_strobe && register_enable[0])
			header_reg <= rx_channel[header_field_width-1:0];  // only the payload bits
		for (int i = 0; i < data_flits; i++)
		begin
			if (write_strobe && register_enable[i+1])
				data_bank[i] <= rx_channel;  // data flits may carry any bit 31
		end
	end

	assign header_field = header_reg;
	assign word_a = {data_bank[0], data_bank[1]};  // first flit of a pair is the upper half
	assign word_b = {data_bank[2], data_bank[3]};

endmodule : nic_input_block

`default_nettype wire

// File: hdl/nic_input_control.sv
`timescale 1ns/1ps
`default_nettype none

// capture sequencer of the input side
// a header flit in idle starts a run of data_flits write cycles, after which the packet
// is handed to the engine as soon as the engine is free and the output has credit
module nic_input_control
	import nic_flit_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  header_marker,    // bit 31 of the input channel
	input  logic                  engine_busy,
	input  logic                  zero_credits,
	output logic                  transfer_strobe,  // one cycle, operands are valid
	output logic                  write_strobe,
	output logic [data_flits:0]   register_enable,  // bit 0 header register, rest data bank
	output logic                  rx_ready
);

	localparam int count_width = (data_flits > 1) ? $clog2(data_flits) : 1;

	typedef enum logic [1:0]
	{
		st_idle,
		st_capture,
		st_decide,
		st_wait
	} ctrl_state_t;

	ctrl_state_t state;
	logic [count_width-1:0] flit_count;  // index of the data flit being written
	logic release_ok;                    // engine and output side can both take a packet

	assign release_ok = !engine_busy && !zero_credits;

	// the header flit is written in the very cycle it shows up, so idle writes on the marker
	assign write_strobe = ((state == st_idle) && header_marker) || (state == st_capture);
	assign transfer_strobe = ((state == st_decide) || (state == st_wait)) && release_ok;
	assign rx_ready = (state == st_idle);  // upstream may only start a packet here

	// ##########################################################################
	// state and enable walk
	// ##########################################################################

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			flit_count <= '0;
			register_enable <= {{data_flits{1'b0}}, 1'b1};  // parked on the header register
		end
		else
		begin
			case (state)
				st_idle:
					if (header_marker)
					begin
						state <= st_capture;
						flit_count <= '0;
						register_enable <= register_enable << 1;  // first data register next
					end
				st_capture:
					if (flit_count == count_width'(data_flits - 1))
					begin
						// last data flit written this cycle, go back to the header slot
						state <= st_decide;
						register_enable <= {{data_flits{1'b0}}, 1'b1};
					end
					else
					begin
						flit_count <= flit_count + 1'b1;
						register_enable <= register_enable << 1;
					end
				st_decide:
					state <= release_ok ? st_idle : st_wait;  // strobe goes out combinationally
				st_wait:
					if (release_ok)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// a new header while a captured packet still waits for the engine means upstream ignored
	// rx_ready and the packet in the data bank is about to be overwritten
	a_no_header_in_wait : assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_wait) |-> !header_marker);

endmodule : nic_input_control

`default_nettype wire

// File: hdl/nic_output_block.sv
`timescale 1ns/1ps
`default_nettype none

// output side of the node
// takes a held result when a credit is left, then sends the rebuilt header flit and the
// four result flits on consecutive cycles
module nic_output_block
	import nic_flit_pkg::*, engine_pkg::*;
#(
	parameter int credit_count = 2
)
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          result_held,
	input  word_t         res_a,
	input  word_t         res_b,
	input  header_field_t res_header,
	input  logic          credit_in,     // one credit back from downstream
	output logic          result_take,
	output logic          zero_credits,
	output flit_t         tx_channel
);

	localparam int credit_width = $clog2(credit_count + 1);
	localparam int count_width = (data_flits > 1) ? $clog2(data_flits) : 1;
	localparam int payload_width = data_flits * channel_width;

	logic [credit_width-1:0]  credits;
	logic [count_width-1:0]   flit_count;    // data flits already put on the channel
	logic                     sending;
	logic [payload_width-1:0] payload;       // result flits, next one in the top slot
	flit_t                    header_flit;

	// header rebuilt from the stored field, marker and processing flag forced high
	always_comb
	begin
		header_flit = flit_t'(res_header);
		header_flit[header_bit] = 1'b1;
		header_flit[proc_flag_bit] = 1'b1;
	end

	assign zero_credits = (credits == '0);
	assign result_take = result_held && !zero_credits && !sending;

	// ##########################################################################
	// credit counter and serializer
	// ##########################################################################

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			credits <= credit_width'(credit_count);
			flit_count <= '0;
			sending <= 1'b0;
			tx_channel <= '0;
		end
		else
		begin
			case ({result_take, credit_in})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;  // both at once cancel out
			endcase
			if (result_take)
			begin
				tx_channel <= header_flit;  // header goes out in the cycle after the take
				sending <= 1'b1;
				flit_count <= '0;
			end
			else if (sending)
			begin
				tx_channel <= payload[payload_width-1 -: channel_width];
				flit_count <= flit_count + 1'b1;
				if (flit_count == count_width'(data_flits - 1))
					sending <= 1'b0;  // last data flit appears next cycle
			end
			else
				tx_channel <= '0;  // idle channel
		end
	end

	// the core may load a new packet once the take has cleared it, so the result is copied
	always_ff @(posedge clk)
	begin
		if (result_take)
			payload <= {res_a, res_b};  // upper half of res_a leads
		else if (sending)
			payload <= payload << channel_width;
	end

	// downstream returns exactly one credit per packet it was sent
	a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
		credits <= credit_width'(credit_count));

endmodule : nic_output_block

`default_nettype wire

// File: hdl/test_engine_core.sv
`timescale 1ns/1ps
`default_nettype none

// round based mixing engine
// one round per cycle, x takes the sum and y is rotated and folded with the new x,
// the result and the packet header stay put until the output side takes them
module test_engine_core
	import nic_flit_pkg::*, engine_pkg::*;
#(
	parameter int engine_rounds = 8
)
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic          transfer_strobe,
	input  word_t         word_a,
	input  word_t         word_b,
	input  header_field_t header_field,
	input  logic          result_take,
	output logic          engine_busy,
	output logic          result_held,
	output word_t         res_a,
	output word_t         res_b,
	output header_field_t res_header
);

	localparam int round_width = $clog2(engine_rounds + 1);

	typedef enum logic [1:0]
	{
		core_idle,
		core_run,
		core_hold
	} core_state_t;

	core_state_t state;
	logic [round_width-1:0] round_cnt;
	word_t x, y;
	word_t x_next, y_next;
	header_field_t hdr_reg;
	logic load;

	assign load = transfer_strobe && (state == core_idle);

	// round function
	assign x_next = x + y;  // wraps modulo 2^64
	assign y_next = ((y << mix_rotate) | (y >> (word_width - mix_rotate))) ^ x_next;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= core_idle;
			round_cnt <= '0;
		end
		else
		begin
			case (state)
				core_idle:
					if (transfer_strobe)
					begin
						state <= core_run;
						round_cnt <= '0;
					end
				core_run:
					if (round_cnt == round_width'(engine_rounds - 1))
						state <= core_hold;  // last round lands with this edge
					else
						round_cnt <= round_cnt + 1'b1;
				core_hold:
					if (result_take)
						state <= core_idle;  // busy drops the cycle after the take
				default:
					state <= core_idle;
			endcase
		end
	end

	// operand and result registers share storage, x and y become res_a and res_b
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			x <= word_a;
			y <= word_b;
			hdr_reg <= header_field;
		end
		else if (state == core_run)
		begin
			x <= x_next;
			y <= y_next;
		end
	end

	assign engine_busy = (state != core_idle);
	assign result_held = (state == core_hold);
	assign res_a = x;
	assign res_b = y;
	assign res_header = hdr_reg;

	// the input side has to hold a captured packet back while the engine is occupied
	a_no_strobe_when_busy : assert property (@(posedge clk) disable iff (!rst_n)
		transfer_strobe |-> !engine_busy);

endmodule : test_engine_core

`default_nettype wire

// File: hdl/test_engine_node.sv
`timescale 1ns/1ps
`default_nettype none

// processing node on a router port: input side, mixing engine and output side
module test_engine_node
	import nic_flit_pkg::*, engine_pkg::*;
#(
	parameter int engine_rounds = 8,
	parameter int credit_count = 2
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  flit_t rx_channel,
	input  logic  credit_in,
	output logic  rx_ready,
	output flit_t tx_channel
);

	word_t         word_a, word_b;        // operands out of the capture bank
	header_field_t header_field;
	logic          transfer_strobe;
	logic          engine_busy;
	logic          zero_credits;
	logic          result_held;
	logic          result_take;
	word_t         res_a, res_b;
	header_field_t res_header;

	nic_input_block u_input_block
	(
		.clk             (clk),
		.rst_n           (rst_n),
		.rx_channel      (rx_channel),
		.engine_busy     (engine_busy),
		.zero_credits    (zero_credits),
		.word_a          (word_a),
		.word_b          (word_b),
		.header_field    (header_field),
		.transfer_strobe (transfer_strobe),
		.rx_ready        (rx_ready)
	);

	test_engine_core #(.engine_rounds(engine_rounds)) u_engine_core
	(
		.clk             (clk),
		.rst_n           (rst_n),
		.transfer_strobe (transfer_strobe),
		.word_a          (word_a),
		.word_b          (word_b),
		.header_field    (header_field),
		.result_take     (result_take),
		.engine_busy     (engine_busy),
		.result_held     (result_held),
		.res_a           (res_a),
		.res_b           (res_b),
		.res_header      (res_header)
	);

	nic_output_block #(.credit_count(credit_count)) u_output_block
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.result_held  (result_held),
		.res_a        (res_a),
		.res_b        (res_b),
		.res_header   (res_header),
		.credit_in    (credit_in),
		.result_take  (result_take),
		.zero_credits (zero_credits),
		.tx_channel   (tx_channel)
	);

endmodule : test_engine_node

`default_nettype wire

// File: verilog.f
hdl/nic_flit_pkg.sv
hdl/engine_pkg.sv
hdl/nic_input_control.sv
hdl/nic_input_block.sv
hdl/test_engine_core.sv
hdl/nic_output_block.sv
hdl/test_engine_node.sv
dv/test_engine_node_tb.sv
